//--- exec_core.f
verilog/exec_pkg.sv
verilog/alu.sv
verilog/branch_resolve.sv
verilog/pipe_control.sv
verilog/exu_stage.sv
verilog/commit_stage.sv
verilog/exec_core.sv
tb/exec_core_tb.sv

//--- tb/exec_core_tb.sv
module exec_core_tb;
    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        logic [31:0] result;
        logic        redirect;
        logic [31:0] target;
        logic [31:0] pc;
        logic [31:0] store_data;
        logic [4:0]  rd;
        logic [2:0]  funct3;
        logic        reg_write;
        logic        mem_write;
        logic        mem_read;
        int          accept_cycle;
    } expect_t;

    localparam int wait_limit = 200;

    logic clock, reset;
    logic [31:0] in_operand_a, in_operand_b, in_pc, in_imm, in_store_data;
    logic [3:0] in_alu_op;
    logic [4:0] in_rd;
    logic [2:0] in_funct3;
    logic in_invert, in_jump, in_branch, in_reg_write, in_mem_write, in_mem_read;
    logic in_kill, in_valid, in_ready, out_ready, out_valid;
    logic [31:0] out_result, out_target, out_pc, out_store_data;
    logic [4:0] out_rd;
    logic [2:0] out_funct3;
    logic out_redirect, out_reg_write, out_mem_write, out_mem_read;

    expect_t expected_q[$];
    int seed = 32'ha23f_02c4;
    int mismatches = 0;
    int other_errors = 0;
    int cycle = 0;
    logic squash_next = 1'b0;
    logic ready_held = 1'b1;
    logic latency_check = 1'b0;
    logic was_stalled = 1'b0;
    logic [139:0] stalled_snapshot;

    exec_core i_dut (.*);

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    function automatic logic [31:0] compute_alu(logic [31:0] a, logic [31:0] b, logic [3:0] op);
        case (op)
            exec_pkg::alu_add:    return a + b;
            exec_pkg::alu_sub:    return a - b;
            exec_pkg::alu_sll:    return a << b[4:0];
            exec_pkg::alu_slt:    return {31'b0, $signed(a) < $signed(b)};
            exec_pkg::alu_sltu:   return {31'b0, a < b};
            exec_pkg::alu_xor:    return a ^ b;
            exec_pkg::alu_srl:    return a >> b[4:0];
            exec_pkg::alu_sra:    return $unsigned($signed(a) >>> b[4:0]);
            exec_pkg::alu_or:     return a | b;
            exec_pkg::alu_and:    return a & b;
            exec_pkg::alu_eq:     return {31'b0, a == b};
            exec_pkg::alu_pass_b: return b;
            default:              return 32'b0;
        endcase
    endfunction

    function automatic logic [139:0] output_snapshot();
        return {out_result, out_redirect, out_target, out_pc, out_store_data, out_rd,
                out_funct3, out_reg_write, out_mem_write, out_mem_read};
    endfunction

    task automatic check_field(string name, logic [31:0] got, logic [31:0] want);
        assert (got === want) else begin
            mismatches++;
            $display("MISMATCH at %0t: %s got %h, expected %h", $time, name, got, want);
        end
    endtask

    task automatic finish_run();
        $display("errors: %0d mismatches, %0d other failures", mismatches, other_errors);
        if (mismatches + other_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    endtask

    always @(posedge clock) begin
        cycle <= cycle + 1;
        if (ready_held) begin
            out_ready <= 1'b1;
        end else begin
            out_ready <= ($random(seed) & 3) != 0;
        end
    end

    // the reference model predicts each accepted operation and checks each transfer.
    always @(posedge clock) begin : monitor
        expect_t e;
        expect_t got;
        logic [31:0] r;
        logic k, j, br;
        if (!reset) begin
            if (was_stalled) begin
                assert (out_valid && output_snapshot() === stalled_snapshot) else begin
                    mismatches++;
                    $display("MISMATCH at %0t: output changed while stalled", $time);
                end
            end
            was_stalled = out_valid && !out_ready;
            stalled_snapshot = output_snapshot();
            if (out_valid && out_ready) begin
                if (expected_q.size() == 0) begin
                    other_errors++;
                    $display("%0t: the DUT delivered an operation that was never sent", $time);
                end else begin
                    got = expected_q.pop_front();
                    check_field("result", out_result, got.result);
                    check_field("redirect", out_redirect, got.redirect);
                    check_field("target", out_target, got.target);
                    check_field("pc", out_pc, got.pc);
                    check_field("store_data", out_store_data, got.store_data);
                    check_field("rd", out_rd, got.rd);
                    check_field("funct3", out_funct3, got.funct3);
                    check_field("reg_write", out_reg_write, got.reg_write);
                    check_field("mem_write", out_mem_write, got.mem_write);
                    check_field("mem_read", out_mem_read, got.mem_read);
                    if (latency_check) begin
                        check_field("latency", cycle - got.accept_cycle, 2);
                    end
                end
            end
            if (in_valid && in_ready) begin
                k = in_kill | squash_next;
                r = compute_alu(in_operand_a, in_operand_b, in_alu_op) ^ {31'b0, in_invert};
                j = in_jump & ~k;
                br = in_branch & ~k;
                e.redirect = j | (br & r[0]);
                e.target = j ? {r[31:1], 1'b0} : in_pc + in_imm;
                e.result = j ? in_pc + 32'd4 : r;
                e.pc = in_pc;
                e.store_data = in_store_data;
                e.rd = in_rd;
                e.funct3 = in_funct3;
                e.reg_write = in_reg_write & ~k;
                e.mem_write = in_mem_write & ~k;
                e.mem_read = in_mem_read & ~k;
                e.accept_cycle = cycle;
                squash_next = e.redirect;
                expected_q.push_back(e);
            end
        end
    end

    // drives one operation and returns on the edge where the DUT accepts it.
    task automatic send_op(logic [3:0] op, logic inv, logic jump, logic branch, logic kill);
        int waited;
        waited = 0;
        in_operand_a <= branch ? ($random(seed) & 3) : $random(seed);
        in_operand_b <= branch ? ($random(seed) & 3) : $random(seed);
        in_alu_op <= op;
        in_invert <= inv;
        in_jump <= jump;
        in_branch <= branch;
        in_pc <= $random(seed) & 32'hffff_fffc;
        in_imm <= $random(seed);
        in_store_data <= $random(seed);
        in_rd <= $random(seed);
        in_funct3 <= $random(seed);
        in_reg_write <= jump | $random(seed);
        in_mem_write <= $random(seed);
        in_mem_read <= $random(seed);
        in_kill <= kill;
        in_valid <= 1'b1;
        do begin
            @(posedge clock);
            waited++;
        end while (!in_ready && waited < wait_limit);
        if (!in_ready) begin
            other_errors++;
            $display("%0t: the DUT never accepted the operation", $time);
            finish_run();
        end
    endtask

    // the model queues an operation on its accepting edge, so at least one edge passes first.
    task automatic wait_drained();
        int waited;
        waited = 0;
        in_valid <= 1'b0;
        do begin
            @(posedge clock);
            waited++;
        end while (expected_q.size() != 0 && waited < wait_limit);
        if (expected_q.size() != 0) begin
            other_errors++;
            $display("%0t: operations still outstanding after the wait limit", $time);
            finish_run();
        end
    endtask

    initial begin
        reset = 1'b1;
        out_ready = 1'b1;
        in_valid = 1'b0;
        in_operand_a = '0;
        in_operand_b = '0;
        in_alu_op = '0;
        in_invert = 1'b0;
        in_jump = 1'b0;
        in_branch = 1'b0;
        in_pc = '0;
        in_imm = '0;
        in_store_data = '0;
        in_rd = '0;
        in_funct3 = '0;
        in_reg_write = 1'b0;
        in_mem_write = 1'b0;
        in_mem_read = 1'b0;
        in_kill = 1'b0;
        repeat (16) @(posedge clock);
        reset <= 1'b0;
        @(posedge clock);
        assert (!out_valid && !out_reg_write && !out_mem_write && !out_mem_read
                && !out_redirect && in_ready) else begin
            mismatches++;
            $display("MISMATCH at %0t: outputs not idle after reset", $time);
        end
        // a lone operation with the output always ready.
        latency_check <= 1'b1;
        send_op(exec_pkg::alu_add, 1'b0, 1'b0, 1'b0, 1'b0);
        wait_drained();
        latency_check <= 1'b0;
        ready_held <= 1'b0;
        for (int op = 0; op < 16; op++) begin
            send_op(op, 1'b0, 1'b0, 1'b0, 1'b0);
            send_op(op, 1'b1, 1'b0, 1'b0, 1'b0);
        end
        for (int n = 0; n < 40; n++) begin
            send_op(exec_pkg::alu_eq, n[0], 1'b0, 1'b1, 1'b0);
            send_op(exec_pkg::alu_slt, n[1], 1'b0, 1'b1, 1'b0);
            send_op(exec_pkg::alu_sltu, n[0], 1'b0, 1'b1, 1'b0);
            send_op(exec_pkg::alu_add, 1'b0, 1'b1, 1'b0, n[2]);
            send_op(exec_pkg::alu_xor, 1'b0, 1'b0, 1'b0, 1'b1);
        end
        for (int n = 0; n < 400; n++) begin
            if (($random(seed) & 7) == 0) begin
                in_valid <= 1'b0;
                @(posedge clock);
            end
            send_op($random(seed), $random(seed), ($random(seed) & 7) == 0,
                    ($random(seed) & 3) == 0, ($random(seed) & 7) == 0);
        end
        wait_drained();
        finish_run();
    end

    initial begin
        #100us;
        other_errors++;
        $display("the simulation ran past its overall time limit");
        finish_run();
    end

endmodule

//--- verilog/exec_core.sv
module exec_core (
    input  logic                                clock,
    input  logic                                reset,
    input  logic [exec_pkg::xlen-1:0]           in_operand_a,
    input  logic [exec_pkg::xlen-1:0]           in_operand_b,
    input  logic [exec_pkg::alu_op_width-1:0]   in_alu_op,
    input  logic                                in_invert,
    input  logic                                in_jump,
    input  logic                                in_branch,
    input  logic [exec_pkg::xlen-1:0]           in_pc,
    input  logic [exec_pkg::xlen-1:0]           in_imm,
    input  logic [exec_pkg::xlen-1:0]           in_store_data,
    input  logic [exec_pkg::reg_addr_width-1:0] in_rd,
    input  logic [2:0]                          in_funct3,
    input  logic                                in_reg_write,
    input  logic                                in_mem_write,
    input  logic                                in_mem_read,
    input  logic                                in_kill,
    input  logic                                in_valid,
    output logic                                in_ready,
    input  logic                                out_ready,
    output logic                                out_valid,
    output logic [exec_pkg::xlen-1:0]           out_result,
    output logic                                out_redirect,
    output logic [exec_pkg::xlen-1:0]           out_target,
    output logic [exec_pkg::xlen-1:0]           out_pc,
    output logic [exec_pkg::xlen-1:0]           out_store_data,
    output logic [exec_pkg::reg_addr_width-1:0] out_rd,
    output logic [2:0]                          out_funct3,
    output logic                                out_reg_write,
    output logic                                out_mem_write,
    output logic                                out_mem_read
);

    logic                                ex_load;
    logic                                ex_squash;
    logic                                commit_load;
    logic                                ex_taken;
    logic [exec_pkg::xlen-1:0]           ex_target;
    logic [exec_pkg::xlen-1:0]           ex_link;
    logic [exec_pkg::xlen-1:0]           ex_result;
    logic                                ex_jump;
    logic                                ex_branch;
    logic [exec_pkg::xlen-1:0]           ex_pc;
    logic [exec_pkg::xlen-1:0]           ex_imm;
    logic [exec_pkg::xlen-1:0]           ex_store_data;
    logic [exec_pkg::reg_addr_width-1:0] ex_rd;
    logic [2:0]                          ex_funct3;
    logic                                ex_reg_write;
    logic                                ex_mem_write;
    logic                                ex_mem_read;

    pipe_control i_pipe_control (
        .clock       (clock),
        .reset       (reset),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .out_ready   (out_ready),
        .ex_taken    (ex_taken),
        .ex_load     (ex_load),
        .ex_squash   (ex_squash),
        .ex_valid    (),
        .commit_load (commit_load),
        .out_valid   (out_valid)
    );

    exu_stage i_exu_stage (
        .clock        (clock),
        .reset        (reset),
        .load         (ex_load),
        .kill         (in_kill | ex_squash),
        .operand_a    (in_operand_a),
        .operand_b    (in_operand_b),
        .alu_op       (in_alu_op),
        .invert       (in_invert),
        .jump         (in_jump),
        .branch       (in_branch),
        .pc           (in_pc),
        .imm          (in_imm),
        .store_data   (in_store_data),
        .rd           (in_rd),
        .funct3       (in_funct3),
        .reg_write    (in_reg_write),
        .mem_write    (in_mem_write),
        .mem_read     (in_mem_read),
        .jump_q       (ex_jump),
        .branch_q     (ex_branch),
        .pc_q         (ex_pc),
        .imm_q        (ex_imm),
        .store_data_q (ex_store_data),
        .rd_q         (ex_rd),
        .funct3_q     (ex_funct3),
        .reg_write_q  (ex_reg_write),
        .mem_write_q  (ex_mem_write),
        .mem_read_q   (ex_mem_read),
        .result       (ex_result)
    );

    branch_resolve i_branch_resolve (
        .jump       (ex_jump),
        .branch     (ex_branch),
        .condition  (ex_result[0]),
        .alu_result (ex_result),
        .pc         (ex_pc),
        .imm        (ex_imm),
        .taken      (ex_taken),
        .target     (ex_target),
        .link       (ex_link)
    );

    commit_stage i_commit_stage (
        .clock          (clock),
        .reset          (reset),
        .load           (commit_load),
        .result         (ex_result),
        .link           (ex_link),
        .taken          (ex_taken),
        .target         (ex_target),
        .jump           (ex_jump),
        .pc             (ex_pc),
        .store_data     (ex_store_data),
        .rd             (ex_rd),
        .funct3         (ex_funct3),
        .reg_write      (ex_reg_write),
        .mem_write      (ex_mem_write),
        .mem_read       (ex_mem_read),
        .out_result     (out_result),
        .out_redirect   (out_redirect),
        .out_target     (out_target),
        .out_pc         (out_pc),
        .out_store_data (out_store_data),
        .out_rd         (out_rd),
        .out_funct3     (out_funct3),
        .out_reg_write  (out_reg_write),
        .out_mem_write  (out_mem_write),
        .out_mem_read   (out_mem_read)
    );

endmodule

//--- verilog/commit_stage.sv
module commit_stage (
    input  logic                                clock,
    input  logic                                reset,
    input  logic                                load,
    input  logic [exec_pkg::xlen-1:0]           result,
    input  logic [exec_pkg::xlen-1:0]           link,
    input  logic                                taken,
    input  logic [exec_pkg::xlen-1:0]           target,
    input  logic                                jump,
    input  logic [exec_pkg::xlen-1:0]           pc,
    input  logic [exec_pkg::xlen-1:0]           store_data,
    input  logic [exec_pkg::reg_addr_width-1:0] rd,
    input  logic [2:0]                          funct3,
    input  logic                                reg_write,
    input  logic                                mem_write,
    input  logic                                mem_read,
    output logic [exec_pkg::xlen-1:0]           out_result,
    output logic                                out_redirect,
    output logic [exec_pkg::xlen-1:0]           out_target,
    output logic [exec_pkg::xlen-1:0]           out_pc,
    output logic [exec_pkg::xlen-1:0]           out_store_data,
    output logic [exec_pkg::reg_addr_width-1:0] out_rd,
    output logic [2:0]                          out_funct3,
    output logic                                out_reg_write,
    output logic                                out_mem_write,
    output logic                                out_mem_read
);

    logic [exec_pkg::xlen-1:0] writeback_value;

    // jumps write the return address, everything else writes the ALU value.
    assign writeback_value = jump ? link : result;

    always_ff @(posedge clock) begin
        if (load) begin
            out_result     <= writeback_value;
            out_target     <= target;
            out_pc         <= pc;
            out_store_data <= store_data;
            out_rd         <= rd;
            out_funct3     <= funct3;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            out_redirect  <= 1'b0;
            out_reg_write <= 1'b0;
            out_mem_write <= 1'b0;
            out_mem_read  <= 1'b0;
        end else if (load) begin
            out_redirect  <= taken;
            out_reg_write <= reg_write;
            out_mem_write <= mem_write;
            out_mem_read  <= mem_read;
        end
    end

endmodule

//--- verilog/exu_stage.sv
module exu_stage (
    input  logic                                clock,
    input  logic                                reset,
    input  logic                                load,
    input  logic                                kill,
    input  logic [exec_pkg::xlen-1:0]           operand_a,
    input  logic [exec_pkg::xlen-1:0]           operand_b,
    input  logic [exec_pkg::alu_op_width-1:0]   alu_op,
    input  logic                                invert,
    input  logic                                jump,
    input  logic                                branch,
    input  logic [exec_pkg::xlen-1:0]           pc,
    input  logic [exec_pkg::xlen-1:0]           imm,
    input  logic [exec_pkg::xlen-1:0]           store_data,
    input  logic [exec_pkg::reg_addr_width-1:0] rd,
    input  logic [2:0]                          funct3,
    input  logic                                reg_write,
    input  logic                                mem_write,
    input  logic                                mem_read,
    output logic                                jump_q,
    output logic                                branch_q,
    output logic [exec_pkg::xlen-1:0]           pc_q,
    output logic [exec_pkg::xlen-1:0]           imm_q,
    output logic [exec_pkg::xlen-1:0]           store_data_q,
    output logic [exec_pkg::reg_addr_width-1:0] rd_q,
    output logic [2:0]                          funct3_q,
    output logic                                reg_write_q,
    output logic                                mem_write_q,
    output logic                                mem_read_q,
    output logic [exec_pkg::xlen-1:0]           result
);

    logic [exec_pkg::xlen-1:0]         operand_a_q;
    logic [exec_pkg::xlen-1:0]         operand_b_q;
    logic [exec_pkg::alu_op_width-1:0] alu_op_q;
    logic                              invert_q;
    logic [exec_pkg::xlen-1:0]         alu_result;

    always_ff @(posedge clock) begin
        if (load) begin
            operand_a_q  <= operand_a;
            operand_b_q  <= operand_b;
            alu_op_q     <= alu_op;
            invert_q     <= invert;
            pc_q         <= pc;
            imm_q        <= imm;
            store_data_q <= store_data;
            rd_q         <= rd;
            funct3_q     <= funct3;
        end
    end

    // a killed operation still flows on, but can neither write nor redirect.
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            jump_q      <= 1'b0;
            branch_q    <= 1'b0;
            reg_write_q <= 1'b0;
            mem_write_q <= 1'b0;
            mem_read_q  <= 1'b0;
        end else if (load) begin
            jump_q      <= jump & ~kill;
            branch_q    <= branch & ~kill;
            reg_write_q <= reg_write & ~kill;
            mem_write_q <= mem_write & ~kill;
            mem_read_q  <= mem_read & ~kill;
        end
    end

    alu i_alu (
        .operand_a (operand_a_q),
        .operand_b (operand_b_q),
        .op        (alu_op_q),
        .result    (alu_result)
    );

    // flipping bit 0 turns slt into bge and eq into bne.
    assign result = alu_result ^ {{(exec_pkg::xlen-1){1'b0}}, invert_q};

endmodule

//--- verilog/pipe_control.sv
module pipe_control (
    input  logic clock,
    input  logic reset,
    input  logic in_valid,
    output logic in_ready,
    input  logic out_ready,
    input  logic ex_taken,
    output logic ex_load,
    output logic ex_squash,
    output logic ex_valid,
    output logic commit_load,
    output logic out_valid
);

    logic commit_ready;
    logic taken_leaving;
    logic squash_pending;

    // the commit register is free when empty or when its contents leave now.
    assign commit_ready = ~out_valid | out_ready;
    assign commit_load  = ex_valid & commit_ready;

    // execute can take a new operation when it is empty or moving on this edge.
    assign in_ready = ~ex_valid | commit_load;
    assign ex_load  = in_valid & in_ready;

    assign taken_leaving = commit_load & ex_taken;

    // the operation after a taken branch or jump is on the wrong path.
    assign ex_squash = ex_load & (squash_pending | taken_leaving);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            ex_valid <= 1'b0;
        end else if (ex_load) begin
            ex_valid <= 1'b1;
        end else if (commit_load) begin
            ex_valid <= 1'b0;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (commit_load) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    // remembers a redirect until the next accepted operation has been squashed.
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            squash_pending <= 1'b0;
        end else if (ex_load) begin
            squash_pending <= 1'b0;
        end else if (taken_leaving) begin
            squash_pending <= 1'b1;
        end
    end

endmodule

//--- verilog/branch_resolve.sv
module branch_resolve (
    input  logic                      jump,
    input  logic                      branch,
    input  logic                      condition,
    input  logic [exec_pkg::xlen-1:0] alu_result,
    input  logic [exec_pkg::xlen-1:0] pc,
    input  logic [exec_pkg::xlen-1:0] imm,
    output logic                      taken,
    output logic [exec_pkg::xlen-1:0] target,
    output logic [exec_pkg::xlen-1:0] link
);

    logic [exec_pkg::xlen-1:0] branch_target;
    logic [exec_pkg::xlen-1:0] jump_target;

    // jumps always redirect, branches only when the compare came out true.
    assign taken = jump | (branch & condition);

    assign branch_target = pc + imm;

    // the ALU already added the base and the offset for jal and jalr.
    assign jump_target = {alu_result[exec_pkg::xlen-1:1], 1'b0};

    assign target = jump ? jump_target : branch_target;

    assign link = pc + exec_pkg::link_offset;

endmodule

//--- verilog/alu.sv
module alu (
    input  logic [exec_pkg::xlen-1:0]         operand_a,
    input  logic [exec_pkg::xlen-1:0]         operand_b,
    input  logic [exec_pkg::alu_op_width-1:0] op,
    output logic [exec_pkg::xlen-1:0]         result
);

    logic [4:0] shamt;

    // RV32I shifts only look at the low five bits of the shift amount.
    assign shamt = operand_b[4:0];

    always_comb begin
        case (op)
            exec_pkg::alu_add: begin
                result = operand_a + operand_b;
            end
            exec_pkg::alu_sub: begin
                result = operand_a - operand_b;
            end
            exec_pkg::alu_sll: begin
                result = operand_a << shamt;
            end
            exec_pkg::alu_slt: begin
                result = {{(exec_pkg::xlen-1){1'b0}}, $signed(operand_a) < $signed(operand_b)};
            end
            exec_pkg::alu_sltu: begin
                result = {{(exec_pkg::xlen-1){1'b0}}, operand_a < operand_b};
            end
            exec_pkg::alu_xor: begin
                result = operand_a ^ operand_b;
            end
            exec_pkg::alu_srl: begin
                result = operand_a >> shamt;
            end
            exec_pkg::alu_sra: begin
                result = $unsigned($signed(operand_a) >>> shamt);
            end
            exec_pkg::alu_or: begin
                result = operand_a | operand_b;
            end
            exec_pkg::alu_and: begin
                result = operand_a & operand_b;
            end
            exec_pkg::alu_eq: begin
                result = {{(exec_pkg::xlen-1){1'b0}}, operand_a == operand_b};
            end
            exec_pkg::alu_pass_b: begin
                // lui arrives with the shifted immediate as the second operand.
                result = operand_b;
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

//--- verilog/exec_pkg.sv
package exec_pkg;

    // datapath and register index widths.
    localparam int xlen           = 32;
    localparam int reg_addr_width = 5;
    localparam int alu_op_width   = 4;

    // ALU opcode encodings. Codes not listed here produce zero.
    localparam logic [alu_op_width-1:0] alu_add    = 4'd0;
    localparam logic [alu_op_width-1:0] alu_sub    = 4'd1;
    localparam logic [alu_op_width-1:0] alu_sll    = 4'd2;
    localparam logic [alu_op_width-1:0] alu_slt    = 4'd3;
    localparam logic [alu_op_width-1:0] alu_sltu   = 4'd4;
    localparam logic [alu_op_width-1:0] alu_xor    = 4'd5;
    localparam logic [alu_op_width-1:0] alu_srl    = 4'd6;
    localparam logic [alu_op_width-1:0] alu_sra    = 4'd7;
    localparam logic [alu_op_width-1:0] alu_or     = 4'd8;
    localparam logic [alu_op_width-1:0] alu_and    = 4'd9;
    localparam logic [alu_op_width-1:0] alu_eq     = 4'd10;
    localparam logic [alu_op_width-1:0] alu_pass_b = 4'd11;

    // a jump writes the address of the following instruction.
    localparam logic [xlen-1:0] link_offset = xlen'(4);

endpackage
